// File: include/spectrum_settings.svh
`ifndef SPECTRUM_SETTINGS_SVH
`define SPECTRUM_SETTINGS_SVH

// horizontal timing in pixels
`define H_ACTIVE 1024
`define H_FP     24
`define H_SYNC   136
`define H_BP     160
`define H_TOTAL  (`H_ACTIVE + `H_FP + `H_SYNC + `H_BP)   // 1344 per line

// vertical timing in lines
`define V_ACTIVE 768
`define V_FP     3
`define V_SYNC   6
`define V_BP     29
`define V_TOTAL  (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP)   // 806 per frame

// tallest bar that still fits on screen
`define AMP_MAX 767

// full intensity of one colour channel
`define COLOR_FULL 8'hFF

// timing output to vga port
`define PIPE_LAT 4

// one bin per active column
`define HIST_BINS 1024

`endif

// File: rtl/spectrum_pkg.sv
`default_nettype none

package spectrum_pkg;

   typedef logic [9:0] bin_t;    // histogram bin == pixel column
   typedef logic [9:0] amp_t;    // bar height
   typedef logic [9:0] line_t;   // line number

   // syncs active low, blank active high
   typedef struct packed {
      logic hsync_b;
      logic vsync_b;
      logic blank;
   } sync_t;

   typedef struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
   } rgb_t;

   // one-cycle write into the histogram
   typedef struct packed {
      logic strobe;
      bin_t bin;
      amp_t amp;
   } hist_wr_t;

   // raster position with its flags
   typedef struct packed {
      logic [10:0] hcount;
      line_t       vcount;
      sync_t       sync;
   } pos_t;

   // nothing on screen, syncs released
   localparam sync_t SYNC_IDLE = '{hsync_b: 1'b1, vsync_b: 1'b1, blank: 1'b1};
   localparam pos_t  POS_IDLE  = '{hcount: '0, vcount: '0, sync: SYNC_IDLE};

endpackage

`default_nettype wire

// File: rtl/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "spectrum_settings.svh"

module video_timing import spectrum_pkg::*; (
   input  wire  clock_27mhz,
   input  wire  reset,
   output pos_t pos
);

   // sync windows
   localparam int H_SYNC_START = `H_ACTIVE + `H_FP;
   localparam int H_SYNC_END   = H_SYNC_START + `H_SYNC;
   localparam int V_SYNC_START = `V_ACTIVE + `V_FP;
   localparam int V_SYNC_END   = V_SYNC_START + `V_SYNC;

   logic [10:0] h_next;
   line_t       v_next;

   ////////////////////////////////////////////////////////////
   // next position
   ////////////////////////////////////////////////////////////

   always_comb begin
      h_next = pos.hcount + 11'd1;
      v_next = pos.vcount;
      if (pos.hcount == 11'(`H_TOTAL - 1)) begin   // end of line
         h_next = '0;
         if (pos.vcount == 10'(`V_TOTAL - 1))       // end of frame
            v_next = '0;
         else
            v_next = pos.vcount + 10'd1;
      end
   end

   ////////////////////////////////////////////////////////////
   // counters and registered flag decode
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clock_27mhz) begin
      if (reset) begin
         // (0,0) is visible, syncs idle
         pos.hcount       <= '0;
         pos.vcount       <= '0;
         pos.sync.hsync_b <= 1'b1;
         pos.sync.vsync_b <= 1'b1;
         pos.sync.blank   <= 1'b0;
      end else begin
         pos.hcount       <= h_next;
         pos.vcount       <= v_next;
         // flags decoded from the next count so they line up
         pos.sync.blank   <= (h_next >= `H_ACTIVE) || (v_next >= `V_ACTIVE);
         pos.sync.hsync_b <= !((h_next >= H_SYNC_START) && (h_next < H_SYNC_END));
         pos.sync.vsync_b <= !((v_next >= V_SYNC_START) && (v_next < V_SYNC_END));
      end
   end

   // count stays inside the line and blank follows it
   hcount_in_range: assert property (@(posedge clock_27mhz) disable iff (reset)
      (pos.hcount < `H_TOTAL)
      && (pos.sync.blank == ((pos.hcount >= `H_ACTIVE) || (pos.vcount >= `V_ACTIVE))));

endmodule

`default_nettype wire

// File: rtl/histogram_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "spectrum_settings.svh"

module histogram_ram import spectrum_pkg::*; (
   input  wire      clock_27mhz,
   input  hist_wr_t hist_wr,
   input  bin_t     rd_bin,
   output amp_t     rd_amp
);

   // one amplitude per bin, maps onto block ram
   amp_t mem [`HIST_BINS];

   // write port from the analysis side
   always_ff @(posedge clock_27mhz) begin
      if (hist_wr.strobe) begin
         mem[hist_wr.bin] <= hist_wr.amp;
      end
   end

   // read port follows the raster
   always_ff @(posedge clock_27mhz) begin
      rd_amp <= mem[rd_bin];   // one cycle latency
   end

endmodule

`default_nettype wire

// File: rtl/video_delay.sv
`timescale 1ns/1ps
`default_nettype none

module video_delay import spectrum_pkg::*; #(
   parameter type      payload_t = sync_t,
   parameter int       DEPTH     = 1,
   parameter payload_t IDLE      = '0
) (
   input  wire      clock_27mhz,
   input  wire      reset,
   input  payload_t din,
   output payload_t dout
);

   payload_t stage [DEPTH];   // stage 0 is the youngest

   always_ff @(posedge clock_27mhz) begin
      if (reset) begin
         for (int i = 0; i < DEPTH; i++) begin
            stage[i] <= IDLE;   // flush to inactive
         end
      end else begin
         stage[0] <= din;
         for (int i = 1; i < DEPTH; i++) begin
            stage[i] <= stage[i-1];
         end
      end
   end

   assign dout = stage[DEPTH-1];

endmodule

`default_nettype wire

// File: rtl/bar_renderer.sv
`timescale 1ns/1ps
`default_nettype none

`include "spectrum_settings.svh"

module bar_renderer import spectrum_pkg::*; (
   input  wire  clock_27mhz,
   input  wire  reset,
   input  amp_t amp,
   input  pos_t pos,
   output rgb_t pixel
);

   line_t       row;        // counted up from the bottom line
   amp_t        divisor;    // clamped bar height
   logic [17:0] dividend;   // row * 255
   logic [17:0] quotient;

   line_t      row_q;
   amp_t       amp_q;
   logic [7:0] quot_q;      // gradient step
   logic       blank_q;
   logic       lit;

   ////////////////////////////////////////////////////////////
   // stage 1: flip, clamp, divide
   ////////////////////////////////////////////////////////////

   always_comb begin
      row      = 10'(`V_ACTIVE - 1) - pos.vcount;
      divisor  = (amp > `AMP_MAX) ? 10'(`AMP_MAX) : amp;
      dividend = 18'(row) * 18'd255;
      // empty bin has no gradient
      quotient = (divisor == '0) ? '0 : dividend / 18'(divisor);
   end

   always_ff @(posedge clock_27mhz) begin
      row_q  <= row;
      amp_q  <= divisor;
      quot_q <= quotient[7:0];   // below 255 on any lit row
   end

   always_ff @(posedge clock_27mhz) begin
      if (reset)
         blank_q <= 1'b1;
      else
         blank_q <= pos.sync.blank;
   end

   ////////////////////////////////////////////////////////////
   // stage 2: bar test and colour
   ////////////////////////////////////////////////////////////

   assign lit = !blank_q && (amp_q > row_q);   // inside the bar

   always_ff @(posedge clock_27mhz) begin
      if (reset) begin
         pixel <= '0;
      end else if (lit) begin
         // red at the base fading to yellow at the top
         pixel.red   <= `COLOR_FULL;
         pixel.green <= `COLOR_FULL - quot_q;
         pixel.blue  <= 8'h00;
      end else begin
         pixel <= '0;
      end
   end

   // lit pixel came from a real division whose step fits one byte
   lit_step_valid: assert property (@(posedge clock_27mhz) disable iff (reset)
      lit |-> ($past(divisor) != '0) && ($past(quotient) < 18'd255));

endmodule

`default_nettype wire

// File: rtl/peak_marker.sv
`timescale 1ns/1ps
`default_nettype none

`include "spectrum_settings.svh"

module peak_marker import spectrum_pkg::*; (
   input  wire  clock_27mhz,
   input  wire  reset,
   input  amp_t amp,
   input  pos_t pos,
   output rgb_t pixel
);

   amp_t best_amp;   // running max on line 0
   bin_t best_bin;
   amp_t mark_amp;   // result shown next frame
   bin_t mark_bin;
   logic hit_q;

   logic search;
   logic latch;

   assign search = !pos.sync.blank && (pos.vcount == '0);
   assign latch  = (pos.vcount == 10'(`V_ACTIVE)) && (pos.hcount == '0);   // first vblank line

   ////////////////////////////////////////////////////////////
   // peak search and latch
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clock_27mhz) begin
      if (reset) begin
         best_amp <= '0;
         best_bin <= '0;
         mark_amp <= '0;   // no marker until a frame is seen
         mark_bin <= '0;
      end else if (latch) begin
         mark_amp <= best_amp;
         mark_bin <= best_bin;
         best_amp <= '0;   // ready for next frame
         best_bin <= '0;
      end else if (search && (amp > best_amp)) begin
         // strictly greater so lowest bin keeps a tie
         best_amp <= amp;
         best_bin <= pos.hcount[9:0];
      end
   end

   ////////////////////////////////////////////////////////////
   // marker column
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clock_27mhz) begin
      if (reset) begin
         hit_q <= 1'b0;
         pixel <= '0;
      end else begin
         hit_q <= !pos.sync.blank && (pos.hcount[9:0] == mark_bin)
                  && (mark_amp != '0);
         pixel.red   <= 8'h00;
         pixel.green <= 8'h00;
         pixel.blue  <= hit_q ? `COLOR_FULL : 8'h00;   // blue line
      end
   end

endmodule

`default_nettype wire

// File: rtl/pixel_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer import spectrum_pkg::*; (
   input  wire   clock_27mhz,
   input  wire   reset,
   input  rgb_t  bar_pixel,
   input  rgb_t  mark_pixel,
   input  sync_t sync,
   output rgb_t  vga_rgb,
   output logic  vga_hsync_b,
   output logic  vga_vsync_b,
   output logic  vga_blank_b
);

   rgb_t mixed;

   // overlay both layers, black outside active video
   assign mixed = sync.blank ? '0 : (bar_pixel | mark_pixel);

   ////////////////////////////////////////////////////////////
   // output registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clock_27mhz) begin
      if (reset) begin
         vga_rgb     <= '0;
         vga_hsync_b <= 1'b1;   // syncs released
         vga_vsync_b <= 1'b1;
         vga_blank_b <= 1'b0;   // dac blanked
      end else begin
         vga_rgb     <= mixed;
         vga_hsync_b <= sync.hsync_b;
         vga_vsync_b <= sync.vsync_b;
         vga_blank_b <= !sync.blank;
      end
   end

   // marker path and sync path stay aligned
   marker_not_blanked: assert property (@(posedge clock_27mhz) disable iff (reset)
      (mark_pixel.blue != 8'h00) |-> !sync.blank);

endmodule

`default_nettype wire

// File: rtl/spectrum_display.sv
`timescale 1ns/1ps
`default_nettype none

`include "spectrum_settings.svh"

module spectrum_display import spectrum_pkg::*; (
   input  wire      clock_27mhz,
   input  wire      reset,
   input  hist_wr_t hist_wr,
   output rgb_t     vga_rgb,
   output logic     vga_hsync_b,
   output logic     vga_vsync_b,
   output logic     vga_blank_b
);

   pos_t  pos;          // k
   pos_t  pos_rd;       // k+1 with the ram data
   amp_t  amp;          // k+1
   rgb_t  bar_pixel;    // k+3
   rgb_t  mark_pixel;   // k+3
   sync_t sync_mix;     // k+3

   video_timing video_timing_inst (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .pos         (pos)
   );

   histogram_ram histogram_ram_inst (
      .clock_27mhz (clock_27mhz),
      .hist_wr     (hist_wr),
      .rd_bin      (pos.hcount[9:0]),
      .rd_amp      (amp)
   );

   // match the ram read latency
   video_delay #(.payload_t(pos_t), .DEPTH(1), .IDLE(POS_IDLE)) pos_delay_inst (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .din         (pos),
      .dout        (pos_rd)
   );

   bar_renderer bar_renderer_inst (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .amp         (amp),
      .pos         (pos_rd),
      .pixel       (bar_pixel)
   );

   peak_marker peak_marker_inst (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .amp         (amp),
      .pos         (pos_rd),
      .pixel       (mark_pixel)
   );

   // syncs skip the two render stages
   video_delay #(.payload_t(sync_t), .DEPTH(`PIPE_LAT - 2), .IDLE(SYNC_IDLE))
      sync_delay_inst (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .din         (pos_rd.sync),
      .dout        (sync_mix)
   );

   pixel_mixer pixel_mixer_inst (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .bar_pixel   (bar_pixel),
      .mark_pixel  (mark_pixel),
      .sync        (sync_mix),
      .vga_rgb     (vga_rgb),
      .vga_hsync_b (vga_hsync_b),
      .vga_vsync_b (vga_vsync_b),
      .vga_blank_b (vga_blank_b)
   );

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clock_27mhz,
   output logic reset
);

   initial begin
      clock_27mhz = 1'b0;
      forever #50 clock_27mhz = ~clock_27mhz;   // 100 ns period
   end

   initial begin
      reset = 1'b1;
      repeat (4) @(posedge clock_27mhz);
      reset <= 1'b0;   // released on an edge like the stimulus
   end

endmodule

`default_nettype wire

// File: bench/tb_spectrum_display.sv
`timescale 1ns/1ps
`default_nettype none

`include "spectrum_settings.svh"

module tb_spectrum_display import spectrum_pkg::*; ();

   localparam int HS_START   = `H_ACTIVE + `H_FP;
   localparam int VS_START   = `V_ACTIVE + `V_FP;
   localparam int WAIT_LIMIT = 2 * `H_TOTAL * `V_TOTAL;   // two frames

   wire      clock_27mhz;
   wire      reset;
   hist_wr_t hist_wr;
   rgb_t     vga_rgb;
   logic     vga_hsync_b;
   logic     vga_vsync_b;
   logic     vga_blank_b;

   integer seed;
   int     errors;
   logic   timed_out;
   logic   started = 1'b0;   // first edge seen
   int     model [`HIST_BINS];   // amplitudes as written
   int     mark_amp;             // peak expected on the current frame
   int     mark_bin;

   // position expected at the vga ports
   int   edges;
   logic exp_valid;
   int   exp_h;
   int   exp_v;
   int   exp_frame;

   int   row;
   int   amp_c;
   int   quot;
   logic lit;
   logic exp_blank;
   logic exp_hs;
   logic exp_vs;
   logic exp_blank_b;
   rgb_t exp_rgb;
   logic care_rg;
   logic care_b;

   tb_clock tb_clock_inst (
      .clock_27mhz (clock_27mhz),
      .reset       (reset)
   );

   spectrum_display spectrum_display_inst (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .hist_wr     (hist_wr),
      .vga_rgb     (vga_rgb),
      .vga_hsync_b (vga_hsync_b),
      .vga_vsync_b (vga_vsync_b),
      .vga_blank_b (vga_blank_b)
   );

   ////////////////////////////////////////////////////////////
   // reference position, lags the dut timing by the pipe
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clock_27mhz) begin
      started <= 1'b1;
      if (reset) begin
         edges     <= 0;
         exp_valid <= 1'b0;
         exp_h     <= 0;
         exp_v     <= 0;
         exp_frame <= 0;
      end else if (!exp_valid) begin
         if (edges == `PIPE_LAT - 1) begin
            exp_valid <= 1'b1;   // position (0,0) reaches the ports
         end else begin
            edges <= edges + 1;
         end
      end else if (exp_h == `H_TOTAL - 1) begin
         exp_h <= 0;
         if (exp_v == `V_TOTAL - 1) begin
            exp_v     <= 0;
            exp_frame <= exp_frame + 1;
         end else begin
            exp_v <= exp_v + 1;
         end
      end else begin
         exp_h <= exp_h + 1;
      end
   end

   // expected port values from the timing and bar rules
   always_comb begin
      row       = `V_ACTIVE - 1 - exp_v;
      amp_c     = model[exp_h % `HIST_BINS];
      amp_c     = (amp_c > `AMP_MAX) ? `AMP_MAX : amp_c;   // clamp
      lit       = amp_c > row;
      quot      = (amp_c == 0) ? 0 : (row * 255 / amp_c) % 256;
      exp_blank = (exp_h >= `H_ACTIVE) || (exp_v >= `V_ACTIVE);
      exp_hs    = !((exp_h >= HS_START) && (exp_h < HS_START + `H_SYNC));
      exp_vs    = !((exp_v >= VS_START) && (exp_v < VS_START + `V_SYNC));
      exp_blank_b   = !exp_blank;
      exp_rgb.red   = lit ? 8'hFF : 8'h00;
      exp_rgb.green = lit ? 8'(255 - quot) : 8'h00;
      exp_rgb.blue  = ((mark_amp != 0) && (exp_h == mark_bin)) ? 8'hFF : 8'h00;
      if (exp_blank) exp_rgb = '0;
      care_rg = !exp_valid || exp_blank || (exp_frame >= 1);   // ram filled
      care_b  = !exp_valid || exp_blank || (exp_frame >= 2);   // peak known
      if (!exp_valid) begin
         exp_hs      = 1'b1;   // idle after reset
         exp_vs      = 1'b1;
         exp_blank_b = 1'b0;
         exp_rgb     = '0;
      end
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   hsync_check: assert property (@(posedge clock_27mhz) started |-> vga_hsync_b == exp_hs)
      else begin
         errors++;
         $display("ERR vga_hsync_b expected %h actual %h", $sampled(exp_hs),
                  $sampled(vga_hsync_b));
      end

   vsync_check: assert property (@(posedge clock_27mhz) started |-> vga_vsync_b == exp_vs)
      else begin
         errors++;
         $display("ERR vga_vsync_b expected %h actual %h", $sampled(exp_vs),
                  $sampled(vga_vsync_b));
      end

   blank_check: assert property (@(posedge clock_27mhz)
      started |-> vga_blank_b == exp_blank_b)
      else begin
         errors++;
         $display("ERR vga_blank_b expected %h actual %h", $sampled(exp_blank_b),
                  $sampled(vga_blank_b));
      end

   // black outside active video
   rgb_blank_check: assert property (@(posedge clock_27mhz)
      started && !vga_blank_b |-> vga_rgb == '0)
      else begin
         errors++;
         $display("ERR vga_rgb expected %h actual %h", 24'h0, $sampled(vga_rgb));
      end

   red_check: assert property (@(posedge clock_27mhz)
      started && care_rg |-> vga_rgb.red == exp_rgb.red)
      else begin
         errors++;
         $display("ERR vga_rgb.red expected %h actual %h", $sampled(exp_rgb.red),
                  $sampled(vga_rgb.red));
      end

   green_check: assert property (@(posedge clock_27mhz)
      started && care_rg |-> vga_rgb.green == exp_rgb.green)
      else begin
         errors++;
         $display("ERR vga_rgb.green expected %h actual %h", $sampled(exp_rgb.green),
                  $sampled(vga_rgb.green));
      end

   blue_check: assert property (@(posedge clock_27mhz)
      started && care_b |-> vga_rgb.blue == exp_rgb.blue)
      else begin
         errors++;
         $display("ERR vga_rgb.blue expected %h actual %h", $sampled(exp_rgb.blue),
                  $sampled(vga_rgb.blue));
      end

   ////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////

   task automatic wait_position(input int frame, input int line);
      int count;
      count = 0;
      while (!(exp_valid && exp_frame == frame && exp_v == line) && count < WAIT_LIMIT) begin
         @(posedge clock_27mhz);
         count++;
      end
      if (count >= WAIT_LIMIT) begin
         timed_out = 1'b1;
         $display("timeout while waiting for frame %0d line %0d", frame, line);
      end
   endtask

   // rewrite every bin in the vertical blanking after frame batch
   task automatic write_batch(input int batch);
      int amp;
      int best;
      int best_bin;
      if (!timed_out) wait_position(batch, `V_ACTIVE + 2);
      if (!timed_out) begin
         best     = 0;
         best_bin = 0;
         for (int i = 0; i < `HIST_BINS; i++) begin   // peak of the frame just shown
            if (model[i] > best) begin
               best     = model[i];
               best_bin = i;
            end
         end
         mark_amp = best;
         mark_bin = best_bin;
         for (int i = 0; i < `HIST_BINS; i++) begin
            amp = 0;   // batch 2 clears everything
            if (batch == 0) begin
               amp = (i % 16 == 0) ? 0 : $unsigned($random(seed)) % 600;
               if (i == 5) amp = 800;     // clamped bar
               if (i == 100) amp = 767;
               if (i == 200) amp = 1023;  // unique peak and clamped
            end else if (batch == 1) begin
               amp = $unsigned($random(seed)) % 500;
               if (i == 300 || i == 700) amp = 800;   // tie, lower bin wins
            end else if (batch == 3) begin
               amp = $unsigned($random(seed)) % 768;
            end
            @(posedge clock_27mhz);
            hist_wr  <= '{strobe: 1'b1, bin: 10'(i), amp: 10'(amp)};
            model[i] = amp;
         end
         @(posedge clock_27mhz);
         hist_wr <= '0;
      end
   endtask

   initial begin
      int count;
      hist_wr   = '0;
      seed      = 32'h87b6_73e8;
      errors    = 0;
      timed_out = 1'b0;
      mark_amp  = 0;
      mark_bin  = 0;
      for (int i = 0; i < `HIST_BINS; i++) model[i] = 0;
      count = 0;
      while (reset !== 1'b0 && count < 20) begin
         @(posedge clock_27mhz);
         count++;
      end
      if (count >= 20) begin
         timed_out = 1'b1;
         $display("timeout while waiting for reset to be released");
      end
      for (int b = 0; b < 4; b++) write_batch(b);
      if (!timed_out) wait_position(5, 0);   // frame 4 fully shown
      $display("errors: %0d, timeouts: %0d", errors, timed_out ? 1 : 0);
      if (errors == 0 && !timed_out)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
rtl/spectrum_pkg.sv
rtl/video_timing.sv
rtl/histogram_ram.sv
rtl/video_delay.sv
rtl/bar_renderer.sv
rtl/peak_marker.sv
rtl/pixel_mixer.sv
rtl/spectrum_display.sv
bench/tb_clock.sv
bench/tb_spectrum_display.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_spectrum_display
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# output goes to the terminal and through the pass search
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
